//--- src/eth_bringup_pkg.sv
//------------------------------
// shared types and defaults for the ethernet bring-up subsystem
// stream beats, port statistics, firmware revision
//------------------------------

package eth_bringup_pkg;

    //------------------------------
    // defaults for the top level
    //------------------------------
    localparam int DEF_ETHCOUNT      = 4;          // gigabit ports on the board
    localparam int DEF_MIN_FRAME     = 64;         // shortest good frame, bytes
    localparam int DEF_HEARTBEAT_DIV = 10_000_000; // half period of 0.5 s at 20 MHz

    localparam int LEN_W = 16;                     // frame length width

    //------------------------------
    // stream beats
    //------------------------------

    // one byte off the MAC receive stream
    typedef struct packed {
        logic [7:0] data; // payload byte
        logic       last; // final byte of frame
        logic       err;  // MAC error flag for this byte
    } rx_beat_t;

    // one byte onto the MAC transmit stream
    typedef struct packed {
        logic [7:0] data; // payload byte
        logic       last; // final byte of frame
    } tx_beat_t;

    //------------------------------
    // status words
    //------------------------------

    // per-port receive counters, all wrap
    typedef struct packed {
        logic [15:0] good_frames; // frames without err and long enough
        logic [15:0] bad_frames;  // err seen or runt
        logic [31:0] rx_bytes;    // every accepted byte
    } port_stats_t;

    // build stamp
    typedef struct packed {
        logic [31:0] date;       // build date word
        logic [31:0] build_time; // build time word
    } fw_rev_t;

endpackage

//--- src/rx_frame_monitor.sv
//------------------------------
// receive frame checker for one port
// counts good frames, bad frames and bytes
//------------------------------

`timescale 1ns/1ps

module rx_frame_monitor
    import eth_bringup_pkg::*;
#(
    parameter int MIN_FRAME = DEF_MIN_FRAME
) (
    input  logic        clk20_g,
    input  logic        rst_n,

    input  logic        rx_valid, // no ready, stream cannot stall
    input  rx_beat_t    rx_beat,

    output port_stats_t stats
);

    //------------------------------
    // frame state
    //------------------------------
    logic [LEN_W-1:0] byte_cnt_q;  // bytes seen so far in current frame
    logic             err_seen_q;  // sticky err over current frame
    port_stats_t      stats_q;     // counters, shown one cycle after the beat

    logic [LEN_W:0]   frame_len;   // length including the current beat
    logic             frame_bad;   // classification on the last beat
    logic             runt;        // shorter than MIN_FRAME

    // one extra bit so a full-length count does not wrap to zero
    assign frame_len = {1'b0, byte_cnt_q} + 1'b1;
    assign runt      = (frame_len < (LEN_W+1)'(MIN_FRAME));
    assign frame_bad = err_seen_q | rx_beat.err | runt;

    //------------------------------
    // per-frame tracking
    //------------------------------
    always_ff @(posedge clk20_g) begin
        if (!rst_n) begin
            byte_cnt_q <= '0;
            err_seen_q <= 1'b0;
        end else if (rx_valid) begin
            if (rx_beat.last) begin
                byte_cnt_q <= '0;                     // ready for next frame
                err_seen_q <= 1'b0;
            end else begin
                if (byte_cnt_q != '1)                 // saturate on jumbo junk
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                err_seen_q <= err_seen_q | rx_beat.err;
            end
        end
    end

    //------------------------------
    // counters
    //------------------------------
    always_ff @(posedge clk20_g) begin
        if (!rst_n) begin
            stats_q <= '0;
        end else if (rx_valid) begin
            stats_q.rx_bytes <= stats_q.rx_bytes + 1'b1; // good or bad alike
            if (rx_beat.last) begin
                if (frame_bad)
                    stats_q.bad_frames  <= stats_q.bad_frames + 1'b1;
                else
                    stats_q.good_frames <= stats_q.good_frames + 1'b1;
            end
        end
    end

    assign stats = stats_q; // registered, latency 1

endmodule

//--- src/tx_test_gen.sv
//------------------------------
// test frame generator for one port
// valid/ready transmit stream, programmable length
//------------------------------

`timescale 1ns/1ps

module tx_test_gen
    import eth_bringup_pkg::*;
#(
    parameter int PORT_ID = 0
) (
    input  logic             clk20_g,
    input  logic             rst_n,

    input  logic             tx_start, // pulse, ignored while busy
    input  logic [LEN_W-1:0] tx_len,   // bytes per frame, 0 means 1
    output logic             tx_busy,

    output logic             tx_valid,
    input  logic             tx_ready,
    output tx_beat_t         tx_beat
);

    //------------------------------
    // state
    //------------------------------
    logic             busy_q;    // frame in progress
    logic [LEN_W-1:0] remain_q;  // bytes left including the one on the bus
    logic [7:0]       data_q;    // current byte, PORT_ID + k
    logic             xfer;      // beat accepted this cycle
    logic             last_beat; // beat on the bus closes the frame

    assign xfer      = busy_q & tx_ready;
    assign last_beat = (remain_q == LEN_W'(1));

    //------------------------------
    // control
    //------------------------------
    always_ff @(posedge clk20_g) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            remain_q <= '0;
        end else if (!busy_q) begin
            if (tx_start) begin
                busy_q   <= 1'b1;
                remain_q <= (tx_len == '0) ? LEN_W'(1) : tx_len; // zero length -> one byte
            end
        end else if (xfer) begin
            if (last_beat)
                busy_q <= 1'b0;                 // drops the cycle after last transfer
            else
                remain_q <= remain_q - 1'b1;
        end
    end

    //------------------------------
    // payload
    //------------------------------
    always_ff @(posedge clk20_g) begin
        if (!busy_q) begin
            if (tx_start)
                data_q <= 8'(PORT_ID);          // byte 0 of frame
        end else if (xfer) begin
            data_q <= data_q + 1'b1;            // wraps mod 256
        end
        // no xfer, hold steady under back-pressure
    end

    //------------------------------
    // outputs
    //------------------------------
    assign tx_busy      = busy_q;
    assign tx_valid     = busy_q;      // a beat is offered for the whole frame
    assign tx_beat.data = data_q;
    assign tx_beat.last = last_beat;

endmodule

//--- src/board_status.sv
//------------------------------
// heartbeat LED, LVDS activity flag and
// firmware revision words
//------------------------------

`timescale 1ns/1ps

module board_status
    import eth_bringup_pkg::*;
#(
    parameter int          HEARTBEAT_DIV = DEF_HEARTBEAT_DIV,
    parameter logic [31:0] FW_DATE       = 32'h0,
    parameter logic [31:0] FW_TIME       = 32'h0
) (
    input  logic        clk20_g,
    input  logic        rst_n,

    input  logic [13:0] usr_lvds,  // async user inputs
    input  logic        lvds_clr,  // clear pulse for the sticky flag
    output logic        lvds_seen,

    output logic        dbg_led,
    output fw_rev_t     fw_rev
);

    localparam int DIV_W = (HEARTBEAT_DIV > 1) ? $clog2(HEARTBEAT_DIV) : 1;

    //------------------------------
    // heartbeat
    //------------------------------
    logic [DIV_W-1:0] div_cnt_q; // cycles since last toggle
    logic             led_q;

    always_ff @(posedge clk20_g) begin
        if (!rst_n) begin
            div_cnt_q <= '0;
            led_q     <= 1'b0;
        end else if (div_cnt_q == DIV_W'(HEARTBEAT_DIV - 1)) begin
            div_cnt_q <= '0;
            led_q     <= ~led_q;               // half period done
        end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
        end
    end

    //------------------------------
    // LVDS activity
    //------------------------------
    logic [13:0] lvds_meta_q;  // first sync stage
    logic [13:0] lvds_sync_q;  // second sync stage
    logic        seen_q;

    always_ff @(posedge clk20_g) begin
        if (!rst_n) begin
            lvds_meta_q <= '0;
            lvds_sync_q <= '0;
            seen_q      <= 1'b0;
        end else begin
            lvds_meta_q <= usr_lvds;
            lvds_sync_q <= lvds_meta_q;
            // clear wins only when nothing is still active
            seen_q      <= (seen_q & ~lvds_clr) | (|lvds_sync_q);
        end
    end

    assign lvds_seen         = seen_q;
    assign dbg_led           = led_q;
    assign fw_rev.date       = FW_DATE; // build stamp
    assign fw_rev.build_time = FW_TIME;

endmodule

//--- src/eth_bringup_top.sv
//------------------------------
// bring-up top: per-port receive checker and test frame
// generator, plus the board status block
//------------------------------

`timescale 1ns/1ps

module eth_bringup_top
    import eth_bringup_pkg::*;
#(
    parameter int          ETHCOUNT      = DEF_ETHCOUNT,
    parameter int          MIN_FRAME     = DEF_MIN_FRAME,
    parameter int          HEARTBEAT_DIV = DEF_HEARTBEAT_DIV,
    parameter logic [31:0] FW_DATE       = 32'h0,
    parameter logic [31:0] FW_TIME       = 32'h0
) (
    input  logic                        clk20_g,
    input  logic                        rst_n,

    //------------------------------
    // MAC receive streams
    //------------------------------
    input  logic        [ETHCOUNT-1:0]  rx_valid,
    input  rx_beat_t    [ETHCOUNT-1:0]  rx_beat,

    //------------------------------
    // MAC transmit streams
    //------------------------------
    input  logic        [ETHCOUNT-1:0]  tx_start,  // per-port start pulse
    input  logic        [LEN_W-1:0]     tx_len,    // shared by all ports
    input  logic        [ETHCOUNT-1:0]  tx_ready,
    output logic        [ETHCOUNT-1:0]  tx_valid,
    output logic        [ETHCOUNT-1:0]  tx_busy,
    output tx_beat_t    [ETHCOUNT-1:0]  tx_beat,

    output port_stats_t [ETHCOUNT-1:0]  stats,     // receive counters

    //------------------------------
    // board status
    //------------------------------
    input  logic        [13:0]          usr_lvds,
    input  logic                        lvds_clr,
    output logic                        lvds_seen,
    output logic                        dbg_led,
    output fw_rev_t                     fw_rev
);

    //------------------------------
    // per-port logic
    //------------------------------
    genvar p;
    generate
        for (p = 0; p < ETHCOUNT; p = p + 1) begin : eth
            rx_frame_monitor #(
                .MIN_FRAME (MIN_FRAME)
            ) rx_mon (
                .clk20_g  (clk20_g),
                .rst_n    (rst_n),
                .rx_valid (rx_valid[p]),
                .rx_beat  (rx_beat[p]),
                .stats    (stats[p])
            );

            tx_test_gen #(
                .PORT_ID (p)                   // seeds the byte pattern
            ) tx_gen (
                .clk20_g  (clk20_g),
                .rst_n    (rst_n),
                .tx_start (tx_start[p]),
                .tx_len   (tx_len),
                .tx_busy  (tx_busy[p]),
                .tx_valid (tx_valid[p]),
                .tx_ready (tx_ready[p]),
                .tx_beat  (tx_beat[p])
            );
        end
    endgenerate

    //------------------------------
    // heartbeat, LVDS, revision
    //------------------------------
    board_status #(
        .HEARTBEAT_DIV (HEARTBEAT_DIV),
        .FW_DATE       (FW_DATE),
        .FW_TIME       (FW_TIME)
    ) status (
        .clk20_g   (clk20_g),
        .rst_n     (rst_n),
        .usr_lvds  (usr_lvds),
        .lvds_clr  (lvds_clr),
        .lvds_seen (lvds_seen),
        .dbg_led   (dbg_led),
        .fw_rev    (fw_rev)
    );

endmodule

//--- verif/tb_eth_tasks.svh
//------------------------------
// compare tasks, receive stream driver and
// transmit stream receiver for the testbench
//------------------------------
`ifndef TB_ETH_TASKS_SVH
`define TB_ETH_TASKS_SVH

//------------------------------
// compare tasks
//------------------------------
task automatic check_stats(input port_stats_t got, input port_stats_t exp, input string msg);
    if (got !== exp) begin
        $display("[ERROR] %0t %s: got %h expected %h", $time, msg, got, exp);
        errors++;
    end
endtask

task automatic check_beat(input tx_beat_t got, input tx_beat_t exp, input string msg);
    if (got !== exp) begin
        $display("[ERROR] %0t %s: got %h expected %h", $time, msg, got, exp);
        errors++;
    end
endtask

task automatic check_rev(input fw_rev_t got, input fw_rev_t exp, input string msg);
    if (got !== exp) begin
        $display("[ERROR] %0t %s: got %h expected %h", $time, msg, got, exp);
        errors++;
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
        $display("[ERROR] %0t %s: got %b expected %b", $time, msg, got, exp);
        errors++;
    end
endtask

//------------------------------
// receive stream driver
//------------------------------
// one beat per clock with err on beat err_at, none if negative
task automatic send_rx_frame(input int port, input int len, input int err_at);
    rx_beat_t beat;
    for (int k = 0; k < len; k++) begin
        beat.data = 8'($urandom);          // random payload
        beat.last = (k == len - 1);
        beat.err  = (k == err_at);
        @(posedge clk20_g);
        rx_valid[port] <= 1'b1;
        rx_beat[port]  <= beat;
    end
    @(posedge clk20_g);                    // last beat taken here
    rx_valid[port] <= 1'b0;
    rx_beat[port]  <= '0;
    exp_stats[port].rx_bytes = exp_stats[port].rx_bytes + 32'(len);
    if (err_at >= 0 || len < MIN_FRAME)    // err or runt
        exp_stats[port].bad_frames = exp_stats[port].bad_frames + 16'd1;
    else
        exp_stats[port].good_frames = exp_stats[port].good_frames + 16'd1;
    @(negedge clk20_g);                    // one cycle latency
    for (int p = 0; p < ETHCOUNT; p++)
        check_stats(stats[p], exp_stats[p], $sformatf("stats port %0d", p));
endtask

//------------------------------
// transmit side
//------------------------------
task automatic pulse_start(input int port, input int len);
    @(posedge clk20_g);
    tx_start[port] <= 1'b1;
    tx_len         <= LEN_W'(len);
    @(posedge clk20_g);                    // start seen by the DUT here
    tx_start[port] <= 1'b0;
endtask

// collects one frame and fires a mid-frame start of poke_len if not negative
task automatic receive_tx_frame(input int port, input int len, input bit rand_ready,
                                input int poke_len);
    tx_beat_t exp_beat;
    tx_beat_t prev_beat;
    bit       held;
    int       count;
    int       cycles;
    held   = 1'b0;
    count  = 0;
    cycles = 0;
    @(negedge clk20_g);
    check_bit(tx_busy[port], 1'b1, "tx_busy one cycle after start");
    check_bit(tx_valid[port], 1'b1, "tx_valid one cycle after start");
    while (tx_busy[port] && cycles < 200) begin
        if (held)                          // stalled last cycle
            check_beat(tx_beat[port], prev_beat, "beat changed under back-pressure");
        if (tx_valid[port] && tx_ready[port]) begin
            exp_beat.data = 8'(port + count);   // byte k is port plus k
            exp_beat.last = (count == len - 1);
            check_beat(tx_beat[port], exp_beat, $sformatf("port %0d byte %0d", port, count));
            count++;
        end
        held      = tx_valid[port] && !tx_ready[port];
        prev_beat = tx_beat[port];
        cycles++;
        @(posedge clk20_g);
        tx_ready[port] <= rand_ready ? 1'($urandom) : 1'b1;
        tx_start[port] <= (poke_len >= 0 && cycles == 3);    // start while busy
        if (poke_len >= 0 && cycles == 3)
            tx_len <= LEN_W'(poke_len);
        @(negedge clk20_g);
    end
    if (tx_busy[port]) begin
        $display("tx_busy on port %0d never fell", port);
        errors++;
    end
    if (count != len) begin
        $display("[ERROR] %0t port %0d sent %0d beats, expected %0d", $time, port, count, len);
        errors++;
    end
    @(posedge clk20_g);
    tx_ready[port] <= 1'b0;
endtask

`endif

//--- verif/tb_eth_bringup.sv
//------------------------------
// testbench for the ethernet bring-up top: clock, reset,
// directed tests and final report
//------------------------------

`timescale 1ns/1ps

module tb_eth_bringup
    import eth_bringup_pkg::*;
();

    localparam int          ETHCOUNT  = 4;
    localparam int          MIN_FRAME = 64;
    localparam int          HB_DIV    = 8;            // short heartbeat for sim
    localparam logic [31:0] FW_DATE   = 32'h0001_0A3C;
    localparam logic [31:0] FW_TIME   = 32'h0000_5E17;

    logic                        clk20_g;
    logic                        rst_n;
    logic        [ETHCOUNT-1:0]  rx_valid;
    rx_beat_t    [ETHCOUNT-1:0]  rx_beat;
    logic        [ETHCOUNT-1:0]  tx_start;
    logic        [LEN_W-1:0]     tx_len;
    logic        [ETHCOUNT-1:0]  tx_ready;
    logic        [ETHCOUNT-1:0]  tx_valid;
    logic        [ETHCOUNT-1:0]  tx_busy;
    tx_beat_t    [ETHCOUNT-1:0]  tx_beat;
    port_stats_t [ETHCOUNT-1:0]  stats;
    logic        [13:0]          usr_lvds;
    logic                        lvds_clr;
    logic                        lvds_seen;
    logic                        dbg_led;
    fw_rev_t                     fw_rev;

    port_stats_t exp_stats [ETHCOUNT];  // reference counters per port
    int          errors;
    int          errors_at_start;       // errors before the running test
    int          tests_run;
    int          tests_bad;

    initial clk20_g = 1'b0;
    always #5 clk20_g = ~clk20_g;       // 10 ns period

    eth_bringup_top #(
        .ETHCOUNT      (ETHCOUNT),
        .MIN_FRAME     (MIN_FRAME),
        .HEARTBEAT_DIV (HB_DIV),
        .FW_DATE       (FW_DATE),
        .FW_TIME       (FW_TIME)
    ) UUT (.*);

`include "tb_eth_tasks.svh"

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s ok", name);
        end else begin
            tests_bad++;
            $display("test %s %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    //------------------------------
    // directed tests
    //------------------------------
    task automatic test_reset_state();
        @(negedge clk20_g);
        check_bit(|tx_valid, 1'b0, "tx_valid after reset");
        check_bit(|tx_busy, 1'b0, "tx_busy after reset");
        check_bit(lvds_seen, 1'b0, "lvds_seen after reset");
        check_bit(dbg_led, 1'b0, "dbg_led after reset");
        for (int p = 0; p < ETHCOUNT; p++)
            check_stats(stats[p], '0, $sformatf("stats port %0d after reset", p));
        finish_test("reset");
    endtask

    task automatic test_good_frames();
        send_rx_frame(0, 64, -1);             // exactly minimum
        send_rx_frame(0, 100, -1);
        finish_test("good_frames");
    endtask

    task automatic test_bad_frames();
        send_rx_frame(0, 63, -1);             // runt
        send_rx_frame(0, 70, 35);             // err mid frame
        finish_test("bad_frames");
    endtask

    task automatic test_tx_backpressure();
        for (int p = 0; p < ETHCOUNT; p++) begin
            pulse_start(p, 20);
            receive_tx_frame(p, 20, 1'b1, -1);
        end
        finish_test("tx_content");
    endtask

    task automatic test_busy_restart();
        pulse_start(1, 10);
        receive_tx_frame(1, 10, 1'b0, 4);     // start with len 4 mid-frame
        repeat (2) @(negedge clk20_g);
        check_bit(tx_busy[1], 1'b0, "start while busy was kept");
        pulse_start(1, 0);                    // zero length gives one beat
        receive_tx_frame(1, 1, 1'b0, -1);
        pulse_start(1, 7);
        receive_tx_frame(1, 7, 1'b1, -1);
        finish_test("busy_restart");
    endtask

    task automatic test_board_status();
        fw_rev_t exp_rev;
        logic    led_prev;
        int      n;
        exp_rev = {FW_DATE, FW_TIME};
        check_rev(fw_rev, exp_rev, "fw_rev");
        @(negedge clk20_g);
        for (int h = 0; h < 3; h++) begin     // first pass only syncs to a toggle
            led_prev = dbg_led;
            n        = 0;
            while (dbg_led === led_prev && n <= 2 * HB_DIV) begin
                @(negedge clk20_g);
                n++;
            end
            if (dbg_led === led_prev) begin
                $display("dbg_led never toggled");
                errors++;
            end else if (h > 0) begin
                check_bit(n == HB_DIV, 1'b1, $sformatf("dbg_led half period %0d cycles", n));
            end
        end
        @(posedge clk20_g);
        usr_lvds <= 14'h0020;                 // one input goes high
        n = 0;
        do begin
            @(posedge clk20_g);
            n++;
            @(negedge clk20_g);
        end while (!lvds_seen && n < 10);
        if (!lvds_seen) begin
            $display("lvds_seen never rose");
            errors++;
        end else begin
            check_bit(n == 3, 1'b1, $sformatf("lvds_seen rose after %0d cycles", n));
        end
        @(posedge clk20_g);
        usr_lvds <= '0;
        repeat (5) @(negedge clk20_g);
        check_bit(lvds_seen, 1'b1, "lvds_seen sticky after input drop");
        @(posedge clk20_g);
        lvds_clr <= 1'b1;
        @(posedge clk20_g);
        lvds_clr <= 1'b0;
        @(negedge clk20_g);
        check_bit(lvds_seen, 1'b0, "lvds_seen after lvds_clr");
        finish_test("board_status");
    endtask

    //------------------------------
    // sequence
    //------------------------------
    initial begin
        void'($urandom(49));
        rst_n    = 1'b0;
        rx_valid = '0;
        rx_beat  = '0;
        tx_start = '0;
        tx_len   = '0;
        tx_ready = '0;
        usr_lvds = '0;
        lvds_clr = 1'b0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_bad       = 0;
        foreach (exp_stats[p])
            exp_stats[p] = '0;
        repeat (3) @(posedge clk20_g);
        rst_n <= 1'b1;
        test_reset_state();
        test_good_frames();
        test_bad_frames();
        test_tx_backpressure();
        test_busy_restart();
        test_board_status();
        $display("tests %0d, failing %0d, errors %0d", tests_run, tests_bad, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- eth_bringup.f
src/eth_bringup_pkg.sv
src/rx_frame_monitor.sv
src/tx_test_gen.sv
src/board_status.sv
src/eth_bringup_top.sv
+incdir+verif
verif/tb_eth_bringup.sv

//--- Makefile
# Verilator build and run for the ethernet bring-up subsystem

VERILATOR  = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_eth_bringup
LINT_TOP   = eth_bringup_top
FILELIST   = eth_bringup.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = *** TEST FAILED ***
PASS_MSG   = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
